/* src/cps_sdram_cfg.svh */
// Address map, widths and sizing for the shared SDRAM port.
// Included by the package and by every module that needs an offset or a bank code.
`ifndef CPS_SDRAM_CFG_SVH
`define CPS_SDRAM_CFG_SVH

// Port widths
`define CPS_SDRAM_AW 22
`define CPS_DATA_W 32
`define CPS_WORD_W 16

// Requesters and request queue
`define CPS_SLOTS 4
`define CPS_FIFO_DEPTH 4

// Base offsets, in SDRAM words
`define CPS_RAM_OFFSET 22'h20_0000
`define CPS_VRAM_OFFSET 22'h30_0000
`define CPS_SOUND_OFFSET 22'h00_0000
`define CPS_GFX_OFFSET 22'h00_0000

// Bank codes
// Work RAM and VRAM live in the sound bank
`define CPS_BANK_CPU 2'd1
`define CPS_BANK_GFX 2'd2
`define CPS_BANK_SND 2'd0

`endif

/* src/cps_sdram_pkg.sv */
// Shared types for the SDRAM slot multiplexer.
// Widths come from the config header; modules refer to these by scoped name.
`include "cps_sdram_cfg.svh"

package cps_sdram_pkg;

    // SDRAM word address and read word
    typedef logic [`CPS_SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [`CPS_DATA_W-1:0] sdram_data_t;

    // Requester data
    typedef logic [`CPS_WORD_W-1:0] cpu_word_t;
    typedef logic [7:0] snd_byte_t;

    // Byte mask, active low
    typedef logic [1:0] wrmask_t;

    typedef logic [1:0] bank_t;

    // Slot index and one bit per slot
    typedef logic [$clog2(`CPS_SLOTS)-1:0] slot_id_t;
    typedef logic [`CPS_SLOTS-1:0] slot_vec_t;

    // Sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_REQ,
        SEQ_DATA
    } seq_state_t;

endpackage

/* src/slot_arbiter.sv */
// Turns slot selects into queued SDRAM requests.
// Lowest slot index wins; each slot has at most one request in flight and
// must drop its select before it is served again.
`include "cps_sdram_cfg.svh"

module slot_arbiter (
    input  logic                       VB,
    input  logic                       rst_n,
    input  logic                       downloading,
    input  logic                       rom_cs,
    input  logic [20:0]                rom_addr,
    input  logic                       ram_cs,
    input  logic                       vram_cs,
    input  logic [16:0]                ram_addr,
    input  logic                       ram_rnw,
    input  cps_sdram_pkg::cpu_word_t   ram_din,
    input  cps_sdram_pkg::wrmask_t     ram_dsn,
    input  logic                       obj_cs,
    input  logic [19:0]                obj_addr,
    input  logic                       obj_half,
    input  logic                       snd_cs,
    input  logic [15:0]                snd_addr,
    input  logic                       full,
    input  cps_sdram_pkg::slot_vec_t   done,
    output logic                       push,
    output cps_sdram_pkg::slot_id_t    push_slot,
    output cps_sdram_pkg::sdram_addr_t push_addr,
    output cps_sdram_pkg::bank_t       push_bank,
    output logic                       push_rnw,
    output cps_sdram_pkg::wrmask_t     push_mask,
    output cps_sdram_pkg::cpu_word_t   push_din
);

    cps_sdram_pkg::slot_vec_t   slot_cs;
    cps_sdram_pkg::slot_vec_t   inflight;
    cps_sdram_pkg::slot_vec_t   served;
    cps_sdram_pkg::slot_vec_t   pending;
    cps_sdram_pkg::slot_id_t    sel_id;
    cps_sdram_pkg::sdram_addr_t sel_addr;
    cps_sdram_pkg::bank_t       sel_bank;
    logic                       sel_valid;
    logic                       grant;

    assign slot_cs = {snd_cs, obj_cs, ram_cs | vram_cs, rom_cs};
    assign pending = slot_cs & ~inflight & ~served;
    // In-flight bits keep queue occupancy within the slot count
    assign grant = sel_valid & ~full & ~downloading;

    // Fixed priority, scanned downwards so the lowest index is left
    always_comb begin
        sel_valid = 1'b0;
        sel_id = '0;
        for (int i = `CPS_SLOTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_valid = 1'b1;
                sel_id = cps_sdram_pkg::slot_id_t'(i);
            end
        end
    end

    always_comb begin
        case (sel_id)
            2'd0: begin
                sel_addr = cps_sdram_pkg::sdram_addr_t'(rom_addr);
                sel_bank = `CPS_BANK_CPU;
            end
            2'd1: begin
                sel_addr = (ram_cs ? `CPS_RAM_OFFSET : `CPS_VRAM_OFFSET)
                         + cps_sdram_pkg::sdram_addr_t'(ram_addr);
                sel_bank = `CPS_BANK_SND;
            end
            2'd2: begin
                // Tile address, half select, then 32-bit alignment
                sel_addr = `CPS_GFX_OFFSET + {obj_addr, obj_half, 1'b0};
                sel_bank = `CPS_BANK_GFX;
            end
            default: begin
                sel_addr = `CPS_SOUND_OFFSET
                         + cps_sdram_pkg::sdram_addr_t'(snd_addr[15:1]);
                sel_bank = `CPS_BANK_SND;
            end
        endcase
    end

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            push <= 1'b0;
            inflight <= '0;
            served <= '0;
        end else begin
            push <= grant;
            served <= served & slot_cs;
            inflight <= inflight & ~done;
            if (grant) begin
                inflight[sel_id] <= 1'b1;
                served[sel_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge VB) begin
        if (grant) begin
            push_slot <= sel_id;
            push_addr <= sel_addr;
            push_bank <= sel_bank;
            push_rnw <= (sel_id == 2'd1) ? ram_rnw : 1'b1;
            push_mask <= (sel_id == 2'd1) ? ram_dsn : 2'b11;
            push_din <= ram_din;
        end
    end

endmodule

/* src/req_fifo.sv */
// Show-ahead queue of SDRAM requests between the arbiter and the sequencer.
// Head fields are valid whenever empty is low; push and pop may share a cycle.
`include "cps_sdram_cfg.svh"

module req_fifo #(
    parameter int depth = `CPS_FIFO_DEPTH
) (
    input  logic                       VB,
    input  logic                       rst_n,
    input  logic                       push,
    input  logic                       pop,
    input  cps_sdram_pkg::slot_id_t    in_slot,
    input  cps_sdram_pkg::sdram_addr_t in_addr,
    input  cps_sdram_pkg::bank_t       in_bank,
    input  logic                       in_rnw,
    input  cps_sdram_pkg::wrmask_t     in_mask,
    input  cps_sdram_pkg::cpu_word_t   in_din,
    output logic                       full,
    output logic                       empty,
    output cps_sdram_pkg::slot_id_t    head_slot,
    output cps_sdram_pkg::sdram_addr_t head_addr,
    output cps_sdram_pkg::bank_t       head_bank,
    output logic                       head_rnw,
    output cps_sdram_pkg::wrmask_t     head_mask,
    output cps_sdram_pkg::cpu_word_t   head_din
);

    localparam int aw = $clog2(depth);

    cps_sdram_pkg::slot_id_t    mem_slot [depth];
    cps_sdram_pkg::sdram_addr_t mem_addr [depth];
    cps_sdram_pkg::bank_t       mem_bank [depth];
    logic                       mem_rnw  [depth];
    cps_sdram_pkg::wrmask_t     mem_mask [depth];
    cps_sdram_pkg::cpu_word_t   mem_din  [depth];
    logic [aw-1:0]              wr_ptr;
    logic [aw-1:0]              rd_ptr;
    logic [aw:0]                count;
    logic                       do_push;
    logic                       do_pop;

    assign full = (count == depth);
    assign empty = (count == 0);
    assign do_push = push & ~full;
    assign do_pop = pop & ~empty;

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge VB) begin
        if (do_push) begin
            mem_slot[wr_ptr] <= in_slot;
            mem_addr[wr_ptr] <= in_addr;
            mem_bank[wr_ptr] <= in_bank;
            mem_rnw[wr_ptr] <= in_rnw;
            mem_mask[wr_ptr] <= in_mask;
            mem_din[wr_ptr] <= in_din;
        end
    end

    // Oldest entry, read without a pop
    assign head_slot = mem_slot[rd_ptr];
    assign head_addr = mem_addr[rd_ptr];
    assign head_bank = mem_bank[rd_ptr];
    assign head_rnw = mem_rnw[rd_ptr];
    assign head_mask = mem_mask[rd_ptr];
    assign head_din = mem_din[rd_ptr];

endmodule

/* src/sdram_sequencer.sv */
// Drives the SDRAM controller request from the head of the request queue.
// Holds the request until ack, waits for data_rdy, then steers read data
// to the owning slot and pulses its done bit while popping the entry.
module sdram_sequencer (
    input  logic                       VB,
    input  logic                       rst_n,
    input  logic                       empty,
    input  cps_sdram_pkg::slot_id_t    head_slot,
    input  cps_sdram_pkg::sdram_addr_t head_addr,
    input  cps_sdram_pkg::bank_t       head_bank,
    input  logic                       head_rnw,
    input  cps_sdram_pkg::wrmask_t     head_mask,
    input  cps_sdram_pkg::cpu_word_t   head_din,
    input  logic                       sdram_ack,
    input  logic                       data_rdy,
    input  cps_sdram_pkg::sdram_data_t data_read,
    input  logic                       snd_lsb,
    output logic                       pop,
    output cps_sdram_pkg::slot_vec_t   done,
    output logic                       sdram_req,
    output cps_sdram_pkg::sdram_addr_t sdram_addr,
    output cps_sdram_pkg::bank_t       sdram_bank,
    output logic                       sdram_rnw,
    output cps_sdram_pkg::wrmask_t     sdram_wrmask,
    output cps_sdram_pkg::cpu_word_t   data_write,
    output cps_sdram_pkg::cpu_word_t   rom_data,
    output cps_sdram_pkg::cpu_word_t   ram_data,
    output cps_sdram_pkg::sdram_data_t obj_data,
    output cps_sdram_pkg::snd_byte_t   snd_data
);

    cps_sdram_pkg::seq_state_t state;
    cps_sdram_pkg::slot_id_t   cur_slot;
    logic                      start;
    logic                      finish;

    // The popped entry is still at the head while pop is high
    assign start = (state == cps_sdram_pkg::SEQ_IDLE) & ~empty & ~pop;
    assign finish = (state == cps_sdram_pkg::SEQ_DATA) & data_rdy;

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            state <= cps_sdram_pkg::SEQ_IDLE;
            sdram_req <= 1'b0;
            pop <= 1'b0;
            done <= '0;
        end else begin
            pop <= finish;
            done <= finish ? cps_sdram_pkg::slot_vec_t'(1) << cur_slot : '0;
            case (state)
                cps_sdram_pkg::SEQ_IDLE: begin
                    if (start) begin
                        sdram_req <= 1'b1;
                        state <= cps_sdram_pkg::SEQ_REQ;
                    end
                end
                cps_sdram_pkg::SEQ_REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state <= cps_sdram_pkg::SEQ_DATA;
                    end
                end
                cps_sdram_pkg::SEQ_DATA: begin
                    if (data_rdy) state <= cps_sdram_pkg::SEQ_IDLE;
                end
                default: state <= cps_sdram_pkg::SEQ_IDLE;
            endcase
        end
    end

    // Request fields stay put from start until the next start
    always_ff @(posedge VB) begin
        if (start) begin
            cur_slot <= head_slot;
            sdram_addr <= head_addr;
            sdram_bank <= head_bank;
            sdram_rnw <= head_rnw;
            sdram_wrmask <= head_mask;
            data_write <= head_din;
        end
    end

    // Read data steering, writes leave the slot data alone
    always_ff @(posedge VB) begin
        if (finish && sdram_rnw) begin
            case (cur_slot)
                2'd0: rom_data <= data_read[15:0];
                2'd1: ram_data <= data_read[15:0];
                2'd2: obj_data <= data_read;
                default: snd_data <= snd_lsb ? data_read[15:8] : data_read[7:0];
            endcase
        end
    end

endmodule

/* src/cps_sdram_mux.sv */
// Shares one SDRAM controller port among the CPU ROM, work RAM/VRAM,
// object graphics ROM and sound ROM requesters.
// Arbiter feeds a request queue which the sequencer drains in order.
`include "cps_sdram_cfg.svh"

module cps_sdram_mux (
    input  logic                       VB,
    input  logic                       rst_n,
    input  logic                       downloading,
    // Main CPU ROM
    input  logic                       rom_cs,
    input  logic [20:0]                rom_addr,
    output cps_sdram_pkg::cpu_word_t   rom_data,
    // Work RAM and VRAM
    input  logic                       ram_cs,
    input  logic                       vram_cs,
    input  logic [16:0]                ram_addr,
    input  logic                       ram_rnw,
    input  cps_sdram_pkg::cpu_word_t   ram_din,
    input  cps_sdram_pkg::wrmask_t     ram_dsn,
    output cps_sdram_pkg::cpu_word_t   ram_data,
    // Object graphics ROM
    input  logic                       obj_cs,
    input  logic [19:0]                obj_addr,
    input  logic                       obj_half,
    output cps_sdram_pkg::sdram_data_t obj_data,
    // Sound CPU ROM
    input  logic                       snd_cs,
    input  logic [15:0]                snd_addr,
    output cps_sdram_pkg::snd_byte_t   snd_data,
    output cps_sdram_pkg::slot_vec_t   slot_ok,
    // SDRAM controller
    output logic                       sdram_req,
    input  logic                       sdram_ack,
    output cps_sdram_pkg::sdram_addr_t sdram_addr,
    output cps_sdram_pkg::bank_t       sdram_bank,
    output logic                       sdram_rnw,
    output cps_sdram_pkg::wrmask_t     sdram_wrmask,
    output cps_sdram_pkg::cpu_word_t   data_write,
    input  logic                       data_rdy,
    input  cps_sdram_pkg::sdram_data_t data_read
);

    logic                       push, pop, full, empty;
    cps_sdram_pkg::slot_id_t    push_slot, head_slot;
    cps_sdram_pkg::sdram_addr_t push_addr, head_addr;
    cps_sdram_pkg::bank_t       push_bank, head_bank;
    logic                       push_rnw, head_rnw;
    cps_sdram_pkg::wrmask_t     push_mask, head_mask;
    cps_sdram_pkg::cpu_word_t   push_din, head_din;

    slot_arbiter u_arbiter (
        .VB(VB), .rst_n(rst_n), .downloading(downloading),
        .rom_cs(rom_cs), .rom_addr(rom_addr),
        .ram_cs(ram_cs), .vram_cs(vram_cs), .ram_addr(ram_addr),
        .ram_rnw(ram_rnw), .ram_din(ram_din), .ram_dsn(ram_dsn),
        .obj_cs(obj_cs), .obj_addr(obj_addr), .obj_half(obj_half),
        .snd_cs(snd_cs), .snd_addr(snd_addr),
        .full(full), .done(slot_ok),
        .push(push), .push_slot(push_slot), .push_addr(push_addr),
        .push_bank(push_bank), .push_rnw(push_rnw), .push_mask(push_mask),
        .push_din(push_din)
    );

    req_fifo #(.depth(`CPS_FIFO_DEPTH)) u_fifo (
        .VB(VB), .rst_n(rst_n), .push(push), .pop(pop),
        .in_slot(push_slot), .in_addr(push_addr), .in_bank(push_bank),
        .in_rnw(push_rnw), .in_mask(push_mask), .in_din(push_din),
        .full(full), .empty(empty),
        .head_slot(head_slot), .head_addr(head_addr), .head_bank(head_bank),
        .head_rnw(head_rnw), .head_mask(head_mask), .head_din(head_din)
    );

    // Slot ok pulses are the sequencer's done vector
    sdram_sequencer u_sequencer (
        .VB(VB), .rst_n(rst_n), .empty(empty),
        .head_slot(head_slot), .head_addr(head_addr), .head_bank(head_bank),
        .head_rnw(head_rnw), .head_mask(head_mask), .head_din(head_din),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read),
        .snd_lsb(snd_addr[0]), .pop(pop), .done(slot_ok),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_bank(sdram_bank),
        .sdram_rnw(sdram_rnw), .sdram_wrmask(sdram_wrmask), .data_write(data_write),
        .rom_data(rom_data), .ram_data(ram_data), .obj_data(obj_data),
        .snd_data(snd_data)
    );

endmodule

/* tb/tb_clock.sv */
// Free-running clock for the testbench.
// Starts low; one full period is given by the period parameter.
module tb_clock #(
    parameter int period = 4
) (
    output logic VB
);

    initial begin
        VB = 1'b0;
        forever #(period / 2) VB = ~VB;
    end

endmodule

/* tb/cps_sdram_mux_assert.sv */
// Concurrent checks on the SDRAM port and the slot ok pulses.
// Bound into cps_sdram_mux from the testbench top.
module cps_sdram_mux_assert (
    input  logic                       VB,
    input  logic                       rst_n,
    input  logic                       sdram_req,
    input  logic                       sdram_ack,
    input  cps_sdram_pkg::sdram_addr_t sdram_addr,
    input  cps_sdram_pkg::bank_t       sdram_bank,
    input  logic                       sdram_rnw,
    input  cps_sdram_pkg::wrmask_t     sdram_wrmask,
    input  cps_sdram_pkg::cpu_word_t   data_write,
    input  logic                       data_rdy,
    input  cps_sdram_pkg::slot_vec_t   slot_ok,
    input  logic                       pop
);

    // Controller may sample the fields on any cycle until it acks
    req_fields_stable: assert property (@(posedge VB) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> $stable(sdram_addr) && $stable(sdram_bank)
            && $stable(sdram_rnw) && $stable(sdram_wrmask) && $stable(data_write))
        else $error("SDRAM request fields changed before ack");

    // One slot per ok, and only right after the controller's data_rdy
    ok_onehot: assert property (@(posedge VB) disable iff (!rst_n)
        slot_ok != '0 |-> $onehot(slot_ok) && $past(data_rdy))
        else $error("slot_ok not one-hot or not one cycle after data_rdy");

    // Finished entry is still at the queue head while pop is high
    no_req_on_pop: assert property (@(posedge VB) disable iff (!rst_n)
        pop |=> !$rose(sdram_req))
        else $error("sdram_req rose while a completed entry was not yet popped");

endmodule

/* tb/cps_sdram_mux_tb.sv */
// Testbench for the SDRAM slot multiplexer.
// Applies a table of slot requests, answers them with a behavioral SDRAM
// controller with random ack and data delays, and checks address, bank,
// request order and returned data of every slot.
`include "cps_sdram_cfg.svh"

module cps_sdram_mux_tb;

    localparam int n_rows = 11;

    typedef struct packed {
        logic [3:0]       cs;
        logic             vram;
        logic             dl;
        logic [20:0]      rom_addr;
        logic [16:0]      ram_addr;
        logic             rnw;
        logic [15:0]      din;
        logic [1:0]       dsn;
        logic [19:0]      obj_addr;
        logic             half;
        logic [15:0]      snd_addr;
        logic [3:0][21:0] exp_addr;
        logic [3:0][1:0]  exp_bank;
        logic [3:0][31:0] exp_data;
    } row_t;

    logic                       VB;
    logic                       rst_n;
    logic                       downloading;
    logic                       rom_cs;
    logic [20:0]                rom_addr;
    logic                       ram_cs;
    logic                       vram_cs;
    logic [16:0]                ram_addr;
    logic                       ram_rnw;
    cps_sdram_pkg::cpu_word_t   ram_din;
    cps_sdram_pkg::wrmask_t     ram_dsn;
    logic                       obj_cs;
    logic [19:0]                obj_addr;
    logic                       obj_half;
    logic                       snd_cs;
    logic [15:0]                snd_addr;
    cps_sdram_pkg::cpu_word_t   rom_data;
    cps_sdram_pkg::cpu_word_t   ram_data;
    cps_sdram_pkg::sdram_data_t obj_data;
    cps_sdram_pkg::snd_byte_t   snd_data;
    cps_sdram_pkg::slot_vec_t   slot_ok;
    logic                       sdram_req;
    logic                       sdram_ack;
    cps_sdram_pkg::sdram_addr_t sdram_addr;
    cps_sdram_pkg::bank_t       sdram_bank;
    logic                       sdram_rnw;
    cps_sdram_pkg::wrmask_t     sdram_wrmask;
    cps_sdram_pkg::cpu_word_t   data_write;
    logic                       data_rdy;
    cps_sdram_pkg::sdram_data_t data_read;

    row_t        rows [n_rows];
    logic [31:0] model_mem [logic [23:0]];
    logic [31:0] rng;

    tb_clock #(.period(4)) u_clock (.VB(VB));

    cps_sdram_mux DUT (
        .VB(VB), .rst_n(rst_n), .downloading(downloading),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data),
        .ram_cs(ram_cs), .vram_cs(vram_cs), .ram_addr(ram_addr), .ram_rnw(ram_rnw),
        .ram_din(ram_din), .ram_dsn(ram_dsn), .ram_data(ram_data),
        .obj_cs(obj_cs), .obj_addr(obj_addr), .obj_half(obj_half), .obj_data(obj_data),
        .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_data(snd_data), .slot_ok(slot_ok),
        .sdram_req(sdram_req), .sdram_ack(sdram_ack), .sdram_addr(sdram_addr),
        .sdram_bank(sdram_bank), .sdram_rnw(sdram_rnw), .sdram_wrmask(sdram_wrmask),
        .data_write(data_write), .data_rdy(data_rdy), .data_read(data_read)
    );

    bind cps_sdram_mux cps_sdram_mux_assert u_assert (
        .VB(VB), .rst_n(rst_n), .sdram_req(sdram_req), .sdram_ack(sdram_ack),
        .sdram_addr(sdram_addr), .sdram_bank(sdram_bank), .sdram_rnw(sdram_rnw),
        .sdram_wrmask(sdram_wrmask), .data_write(data_write), .data_rdy(data_rdy),
        .slot_ok(slot_ok), .pop(pop)
    );

    // Content of a word never written, spread over bank and address
    function automatic logic [31:0] fill_word(input logic [1:0] bank, input logic [21:0] addr);
        return {8'h00, bank, addr} ^ 32'h5AC3_96E1;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s (got %h, expected %h)",
                     $time, msg, actual, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    function automatic row_t make_row(
        input logic [3:0]  cs,
        input logic        vram,
        input logic        dl,
        input logic [20:0] rom_a,
        input logic [16:0] ram_a,
        input logic        rnw,
        input logic [15:0] din,
        input logic [1:0]  dsn,
        input logic [19:0] obj_a,
        input logic        half,
        input logic [15:0] snd_a
    );
        row_t        r;
        logic [31:0] w;
        r.cs = cs;
        r.vram = vram;
        r.dl = dl;
        r.rom_addr = rom_a;
        r.ram_addr = ram_a;
        r.rnw = rnw;
        r.din = din;
        r.dsn = dsn;
        r.obj_addr = obj_a;
        r.half = half;
        r.snd_addr = snd_a;
        r.exp_addr[0] = {1'b0, rom_a};
        r.exp_addr[1] = (vram ? `CPS_VRAM_OFFSET : `CPS_RAM_OFFSET) + {5'd0, ram_a};
        r.exp_addr[2] = `CPS_GFX_OFFSET + {obj_a, half, 1'b0};
        r.exp_addr[3] = `CPS_SOUND_OFFSET + {7'd0, snd_a[15:1]};
        // Slot 3 down to slot 0
        r.exp_bank = {2'd0, 2'd2, 2'd0, 2'd1};
        w = fill_word(2'd1, r.exp_addr[0]);
        r.exp_data[0] = {16'h0, w[15:0]};
        w = fill_word(2'd0, r.exp_addr[1]);
        r.exp_data[1] = {16'h0, w[15:0]};
        r.exp_data[2] = fill_word(2'd2, r.exp_addr[2]);
        w = fill_word(2'd0, r.exp_addr[3]);
        r.exp_data[3] = {24'h0, snd_a[0] ? w[15:8] : w[7:0]};
        return r;
    endfunction

    task automatic apply_row(input row_t t);
        int         order [$];
        logic [3:0] got_ok;
        logic       req_prev;
        int         s;
        downloading = t.dl;
        rom_cs = t.cs[0];
        rom_addr = t.rom_addr;
        ram_cs = t.cs[1] & ~t.vram;
        vram_cs = t.cs[1] & t.vram;
        ram_addr = t.ram_addr;
        ram_rnw = t.rnw;
        ram_din = t.din;
        ram_dsn = t.dsn;
        obj_cs = t.cs[2];
        obj_addr = t.obj_addr;
        obj_half = t.half;
        snd_cs = t.cs[3];
        snd_addr = t.snd_addr;
        if (t.dl) begin
            repeat (8) begin
                @(negedge VB);
                check(sdram_req, 1'b0, "sdram_req raised while downloading");
            end
            downloading = 1'b0;
        end
        // Requests must come out lowest slot first
        for (int i = 0; i < 4; i++) begin
            if (t.cs[i]) order.push_back(i);
        end
        got_ok = '0;
        req_prev = sdram_req;
        while (got_ok != t.cs) begin
            @(negedge VB);
            if (sdram_req && !req_prev) begin
                check(order.size() != 0, 1'b1, "sdram_req with no slot pending");
                s = order.pop_front();
                check(sdram_addr, t.exp_addr[s], $sformatf("sdram_addr of slot %0d", s));
                check(sdram_bank, t.exp_bank[s], $sformatf("sdram_bank of slot %0d", s));
                // Only slot 1 can write
                check(sdram_rnw, (s == 1) ? t.rnw : 1'b1,
                      $sformatf("sdram_rnw of slot %0d", s));
                if (s == 1 && !t.rnw) begin
                    check(sdram_wrmask, t.dsn, "sdram_wrmask of write");
                    check(data_write, t.din, "data_write of write");
                end
            end
            req_prev = sdram_req;
            for (int i = 0; i < 4; i++) begin
                if (slot_ok[i]) begin
                    check(t.cs[i] && !got_ok[i], 1'b1, $sformatf("unexpected ok, slot %0d", i));
                    got_ok[i] = 1'b1;
                    case (i)
                        0: check({16'h0, rom_data}, t.exp_data[0], "rom_data");
                        1: if (t.rnw) check({16'h0, ram_data}, t.exp_data[1], "ram_data");
                        2: check(obj_data, t.exp_data[2], "obj_data");
                        default: check({24'h0, snd_data}, t.exp_data[3], "snd_data");
                    endcase
                end
            end
        end
        // Selects still high, nothing may be requested again
        repeat (4) begin
            @(negedge VB);
            check(sdram_req, 1'b0, "second sdram_req with select held");
            check(slot_ok, 4'b0, "extra slot_ok with select held");
        end
        rom_cs = 1'b0;
        ram_cs = 1'b0;
        vram_cs = 1'b0;
        obj_cs = 1'b0;
        snd_cs = 1'b0;
        repeat (2) @(negedge VB);
    endtask

    // Behavioral SDRAM controller
    initial begin : sdram_model
        logic [23:0] key;
        logic [31:0] word;
        sdram_ack = 1'b0;
        data_rdy = 1'b0;
        data_read = '0;
        rng = 32'd31;
        forever begin
            @(negedge VB);
            if (sdram_req === 1'b1) begin
                rng = lcg_next(rng);
                repeat (rng[17:16]) @(negedge VB);
                key = {sdram_bank, sdram_addr};
                word = model_mem.exists(key) ? model_mem[key] : fill_word(sdram_bank, sdram_addr);
                if (!sdram_rnw) begin
                    if (!sdram_wrmask[0]) word[7:0] = data_write[7:0];
                    if (!sdram_wrmask[1]) word[15:8] = data_write[15:8];
                    model_mem[key] = word;
                end
                sdram_ack = 1'b1;
                @(negedge VB);
                sdram_ack = 1'b0;
                rng = lcg_next(rng);
                repeat (rng[17:16]) @(negedge VB);
                data_read = word;
                data_rdy = 1'b1;
                @(negedge VB);
                data_rdy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat ((n_rows + 1) * 64) @(posedge VB);
        $display("Timeout: the table was not finished within the allowed cycles");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin : stimulus
        logic [31:0] w;
        rst_n = 1'b0;
        downloading = 1'b0;
        rom_cs = 1'b0;
        rom_addr = '0;
        ram_cs = 1'b0;
        vram_cs = 1'b0;
        ram_addr = '0;
        ram_rnw = 1'b1;
        ram_din = '0;
        ram_dsn = 2'b11;
        obj_cs = 1'b0;
        obj_addr = '0;
        obj_half = 1'b0;
        snd_cs = 1'b0;
        snd_addr = '0;
        // cs, vram, dl, rom, ram, rnw, din, dsn, obj, half, snd
        rows[0] = make_row(4'b0001, 0, 0, 21'h15_3A5C, 17'h0, 1, 16'h0, 2'b11, 20'h0, 0, 16'h0);
        rows[1] = make_row(4'b0010, 0, 0, 21'h0, 17'h1_2345, 1, 16'h0, 2'b11, 20'h0, 0, 16'h0);
        rows[2] = make_row(4'b0010, 1, 0, 21'h0, 17'h0_0ABC, 1, 16'h0, 2'b11, 20'h0, 0, 16'h0);
        rows[3] = make_row(4'b0100, 0, 0, 21'h0, 17'h0, 1, 16'h0, 2'b11, 20'hA_BCDE, 1, 16'h0);
        rows[4] = make_row(4'b1000, 0, 0, 21'h0, 17'h0, 1, 16'h0, 2'b11, 20'h0, 0, 16'h1235);
        rows[5] = make_row(4'b1000, 0, 0, 21'h0, 17'h0, 1, 16'h0, 2'b11, 20'h0, 0, 16'h4AB0);
        rows[6] = make_row(4'b0010, 0, 0, 21'h0, 17'h0_0F0F, 0, 16'hBEEF, 2'b10, 20'h0, 0, 16'h0);
        rows[7] = make_row(4'b0010, 0, 0, 21'h0, 17'h0_0F0F, 1, 16'h0, 2'b11, 20'h0, 0, 16'h0);
        rows[8] = make_row(4'b1111, 0, 0, 21'h00_1234, 17'h1_0001, 1, 16'h0, 2'b11,
                           20'h0_0042, 0, 16'h0101);
        rows[9] = make_row(4'b0001, 0, 1, 21'h1F_FFFE, 17'h0, 1, 16'h0, 2'b11, 20'h0, 0, 16'h0);
        rows[10] = make_row(4'b1100, 0, 1, 21'h0, 17'h0, 1, 16'h0, 2'b11, 20'h5_5555, 0,
                            16'h8000);
        // Low byte written by row 6, high byte keeps the fill pattern
        w = fill_word(2'd0, rows[7].exp_addr[1]);
        rows[7].exp_data[1] = {16'h0, w[15:8], 8'hEF};

        repeat (4) @(negedge VB);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge VB);
            check(sdram_req, 1'b0, "sdram_req after reset");
            check(slot_ok, 4'b0, "slot_ok after reset");
        end
        for (int r = 0; r < n_rows; r++) begin
            apply_row(rows[r]);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* cps_sdram_mux.f */
+incdir+src
src/cps_sdram_pkg.sv
src/slot_arbiter.sv
src/req_fifo.sv
src/sdram_sequencer.sv
src/cps_sdram_mux.sv
tb/tb_clock.sv
tb/cps_sdram_mux_assert.sv
tb/cps_sdram_mux_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cps_sdram_mux_tb
FILELIST  := cps_sdram_mux.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
